// File: design/remap_pkg.sv
package remap_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Patch geometry
    ////////////////////////////////////////////////////////////////////////////

    // Patch-size opcode, the code is the window width itself
    typedef enum logic [2:0] {
        PATCH_3 = 3'd3,
        PATCH_5 = 3'd5,
        PATCH_7 = 3'd7
    } patch_size_e;

    // Window stride, 1 to 7 are legal
    typedef logic [2:0] stride_t;

    // Widest window in pixels
    localparam int MAX_PATCH = 7;

    // Pixels of the previous word a window may still reach back into
    localparam int RESIDUE_W = MAX_PATCH - 1;

    // One lane's window, bit 0 is the oldest pixel
    typedef logic [MAX_PATCH-1:0] window_t;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // Window width for a patch code, 0 for an illegal code
    function automatic int unsigned patch_width(patch_size_e size);
        case (size)
            PATCH_3:
                return 3;
            PATCH_5:
                return 5;
            PATCH_7:
                return 7;
            default:
                return 0;
        endcase
    endfunction

endpackage

// File: design/stride_phase.sv
`timescale 1ns/1ps

module stride_phase
    import remap_pkg::*;
#(
    parameter int WORD_W = 8,
    parameter int POS_W  = 3
)
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cfg_load,
    input  stride_t                      stride,
    input  patch_size_e                  patch_size,
    input  logic                         pixel_valid,
    output logic [WORD_W-1:0][POS_W-1:0] lane_end,
    output logic [WORD_W-1:0]            lane_active
);

    // Current-word pixel where lane 0's window ends
    logic [POS_W-1:0] phase;
    logic [POS_W-1:0] phase_next;
    logic             config_ok;

    // Illegal patch code or zero stride kills every lane
    assign config_ok = (patch_width(patch_size) != 0) && (stride != '0);

    ////////////////////////////////////////////////////////////////////////////
    // Lane plan for the word at the input
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        int unsigned end_pos;
        int unsigned count;

        count = 0;
        for (int j = 0; j < WORD_W; j++)
        begin
            end_pos = phase + j * stride;
            lane_active[j] = config_ok && (end_pos < WORD_W);
            lane_end[j] = lane_active[j] ? end_pos[POS_W-1:0] : '0;
            if (lane_active[j])
                count++;
        end

        // Next word starts one stride after this word's last window
        if (count == 0)
            phase_next = '0;
        else
            phase_next = POS_W'(phase + count * stride - WORD_W);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Phase register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            phase <= '0;
        end
        else if (cfg_load)
        begin
            phase <= '0;
        end
        else if (pixel_valid)
        begin
            phase <= phase_next;
        end
    end

endmodule

// File: design/residue_buffer.sv
`timescale 1ns/1ps

module residue_buffer
    import remap_pkg::*;
#(
    parameter int WORD_W = 8,
    parameter int POS_W  = 3,
    parameter int CTX_W  = RESIDUE_W + WORD_W
)
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cfg_load,
    input  logic                         pixel_valid,
    input  logic [WORD_W-1:0]            pixel_in,
    input  logic [WORD_W-1:0][POS_W-1:0] lane_end_in,
    input  logic [WORD_W-1:0]            lane_active_in,
    output logic [CTX_W-1:0]             ctx,
    output logic [WORD_W-1:0][POS_W-1:0] lane_end,
    output logic [WORD_W-1:0]            lane_active,
    output logic                         ctx_valid
);

    // Tail pixels of the last accepted word with the oldest in bit 0
    logic [RESIDUE_W-1:0] residue;

    // Residue store
    always_ff @(posedge clk)
    begin
        if (rst || cfg_load)
        begin
            residue <= '0;
        end
        else if (pixel_valid)
        begin
            residue <= pixel_in[WORD_W-1 -: RESIDUE_W];
        end
    end

    // Context and lane plan captured once per word
    always_ff @(posedge clk)
    begin
        if (pixel_valid)
        begin
            ctx         <= {pixel_in, residue};
            lane_end    <= lane_end_in;
            lane_active <= lane_active_in;
        end
    end

    // One-cycle strobe that follows the context
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ctx_valid <= 1'b0;
        end
        else
        begin
            ctx_valid <= pixel_valid;
        end
    end

endmodule

// File: design/window_extract.sv
`timescale 1ns/1ps

module window_extract
    import remap_pkg::*;
#(
    parameter int WORD_W = 8,
    parameter int POS_W  = 3,
    parameter int CTX_W  = RESIDUE_W + WORD_W
)
(
    input  logic                         clk,
    input  logic                         rst,
    input  patch_size_e                  patch_size,
    input  logic [CTX_W-1:0]             ctx,
    input  logic [WORD_W-1:0][POS_W-1:0] lane_end,
    input  logic [WORD_W-1:0]            lane_active,
    input  logic                         ctx_valid,
    output window_t [WORD_W-1:0]         lane_windows,
    output logic [WORD_W-1:0]            lane_mask,
    output logic                         out_valid
);

    window_t [WORD_W-1:0] win_next;

    ////////////////////////////////////////////////////////////////////////////
    // Window selection
    ////////////////////////////////////////////////////////////////////////////

    // A window of width P ending at current pixel e starts at context
    // position RESIDUE_W + e - (P - 1)
    always_comb
    begin
        int unsigned width;
        int unsigned base;

        width = patch_width(patch_size);
        base  = 0;
        for (int j = 0; j < WORD_W; j++)
        begin
            win_next[j] = '0;
            if (lane_active[j] && (width != 0))
            begin
                base = RESIDUE_W + lane_end[j] - (width - 1);
                for (int i = 0; i < MAX_PATCH; i++)
                begin
                    // Bits past the patch width stay zero
                    if (i < width)
                        win_next[j][i] = ctx[base + i];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lane_windows <= '0;
            lane_mask    <= '0;
        end
        else if (ctx_valid)
        begin
            lane_windows <= win_next;
            lane_mask    <= lane_active;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= ctx_valid;
        end
    end

endmodule

// File: design/remap_top.sv
`timescale 1ns/1ps

module remap_top
    import remap_pkg::*;
#(
    parameter int WORD_W = 8,
    parameter int POS_W  = 3,
    parameter int CTX_W  = RESIDUE_W + WORD_W
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cfg_load,
    input  stride_t              stride,
    input  patch_size_e          patch_size,
    input  logic                 pixel_valid,
    input  logic [WORD_W-1:0]    pixel_in,
    output window_t [WORD_W-1:0] lane_windows,
    output logic [WORD_W-1:0]    lane_mask,
    output logic                 out_valid
);

    // Active configuration
    stride_t     stride_q;
    patch_size_e patch_q;

    // Lane plan from the phase stage
    logic [WORD_W-1:0][POS_W-1:0] plan_end;
    logic [WORD_W-1:0]            plan_active;

    // Buffered context and its lane plan
    logic [CTX_W-1:0]             ctx;
    logic [WORD_W-1:0][POS_W-1:0] ctx_end;
    logic [WORD_W-1:0]            ctx_active;
    logic                         ctx_valid;

    ////////////////////////////////////////////////////////////////////////////
    // Configuration registers
    ////////////////////////////////////////////////////////////////////////////

    // Zero stride out of reset keeps every lane idle until configured
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            stride_q <= '0;
            patch_q  <= PATCH_3;
        end
        else if (cfg_load)
        begin
            stride_q <= stride;
            patch_q  <= patch_size;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Datapath stages
    ////////////////////////////////////////////////////////////////////////////

    stride_phase #(.WORD_W(WORD_W), .POS_W(POS_W)) stride_phase_inst (
        .clk         (clk),
        .rst         (rst),
        .cfg_load    (cfg_load),
        .stride      (stride_q),
        .patch_size  (patch_q),
        .pixel_valid (pixel_valid),
        .lane_end    (plan_end),
        .lane_active (plan_active)
    );

    residue_buffer #(.WORD_W(WORD_W), .POS_W(POS_W), .CTX_W(CTX_W)) residue_buffer_inst (
        .clk            (clk),
        .rst            (rst),
        .cfg_load       (cfg_load),
        .pixel_valid    (pixel_valid),
        .pixel_in       (pixel_in),
        .lane_end_in    (plan_end),
        .lane_active_in (plan_active),
        .ctx            (ctx),
        .lane_end       (ctx_end),
        .lane_active    (ctx_active),
        .ctx_valid      (ctx_valid)
    );

    window_extract #(.WORD_W(WORD_W), .POS_W(POS_W), .CTX_W(CTX_W)) window_extract_inst (
        .clk          (clk),
        .rst          (rst),
        .patch_size   (patch_q),
        .ctx          (ctx),
        .lane_end     (ctx_end),
        .lane_active  (ctx_active),
        .ctx_valid    (ctx_valid),
        .lane_windows (lane_windows),
        .lane_mask    (lane_mask),
        .out_valid    (out_valid)
    );

endmodule

// File: bench/remap_model.svh
`ifndef REMAP_MODEL_SVH
`define REMAP_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Reference model of the window and phase rules
////////////////////////////////////////////////////////////////////////////

// Patch code is its own width, anything else is illegal
function automatic int model_width(logic [2:0] code);
    if (code == 3'd3 || code == 3'd5 || code == 3'd7)
        return int'(code);
    else
        return 0;
endfunction

// Lane j is live while its window end stays inside the word
function automatic logic [7:0] model_mask(logic [2:0] code, logic [2:0] stride, int phase);
    logic [7:0] mask;

    mask = 8'h00;
    if (model_width(code) != 0 && stride != 3'd0)
    begin
        for (int j = 0; j < 8; j++)
        begin
            if (phase + j * int'(stride) <= 7)
                mask[j] = 1'b1;
        end
    end
    return mask;
endfunction

// Phase for the next word, one stride past the last window
function automatic int model_phase(logic [2:0] code, logic [2:0] stride, int phase);
    int lanes;

    lanes = $countones(model_mask(code, stride, phase));
    if (lanes == 0)
        return 0;
    return phase + lanes * int'(stride) - 8;
endfunction

function automatic window_t model_window(logic [2:0] code, logic [2:0] stride, int phase,
                                         int lane, logic [13:0] ctx);
    window_t    w;
    logic [7:0] mask;
    int         width;
    int         last;
    int         first;

    w     = '0;
    mask  = model_mask(code, stride, phase);
    width = model_width(code);
    if (mask[lane])
    begin
        last  = phase + lane * int'(stride);
        // Current word starts at context position 6
        first = 6 + last - (width - 1);
        for (int i = 0; i < width; i++)
            w[i] = ctx[first + i];
    end
    return w;
endfunction

`endif

// File: bench/remap_tb.sv
`timescale 1ns/1ps

module remap_tb
    import remap_pkg::*;
();

    `include "remap_model.svh"

    localparam int WORD_W     = 8;
    localparam int MAX_ROWS   = 64;
    localparam int CLK_PERIOD = 8;

    logic                 clk;
    logic                 rst;
    logic                 cfg_load;
    stride_t              stride;
    patch_size_e          patch_size;
    logic                 pixel_valid;
    logic [WORD_W-1:0]    pixel_in;
    window_t [WORD_W-1:0] lane_windows;
    logic [WORD_W-1:0]    lane_mask;
    logic                 out_valid;

    // Stimulus table and expected results
    string             row_name   [MAX_ROWS];
    bit                row_cfg    [MAX_ROWS];
    logic [2:0]        row_stride [MAX_ROWS];
    logic [2:0]        row_patch  [MAX_ROWS];
    logic [WORD_W-1:0] row_word   [MAX_ROWS];
    bit                row_gap    [MAX_ROWS];
    logic [WORD_W-1:0] exp_mask   [MAX_ROWS];
    window_t           exp_win    [MAX_ROWS][WORD_W];

    int row_count;
    int cur_row;
    int seed;
    bit table_ready;

    remap_top #(.WORD_W(WORD_W), .POS_W(3), .CTX_W(14)) remap_top_inst (
        .clk          (clk),
        .rst          (rst),
        .cfg_load     (cfg_load),
        .stride       (stride),
        .patch_size   (patch_size),
        .pixel_valid  (pixel_valid),
        .pixel_in     (pixel_in),
        .lane_windows (lane_windows),
        .lane_mask    (lane_mask),
        .out_valid    (out_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Table construction
    ////////////////////////////////////////////////////////////////////////////

    task automatic add_row(string name, bit cfg, logic [2:0] strd, logic [2:0] patch,
                           logic [7:0] word, bit gap);
        row_name[row_count]   = name;
        row_cfg[row_count]    = cfg;
        row_stride[row_count] = strd;
        row_patch[row_count]  = patch;
        row_word[row_count]   = word;
        row_gap[row_count]    = gap;
        row_count++;
    endtask

    task automatic build_table();
        add_row("s1_p3_a", 1'b1, 3'd1, 3'd3, 8'hA5, 1'b0);
        add_row("s1_p3_b", 1'b0, 3'd0, 3'd0, 8'h3C, 1'b0);
        add_row("s1_p3_c", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b1);
        add_row("s1_p5_a", 1'b1, 3'd1, 3'd5, 8'hFF, 1'b0);
        add_row("s1_p5_b", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b0);
        add_row("s1_p7_a", 1'b1, 3'd1, 3'd7, 8'h81, 1'b0);
        add_row("s1_p7_b", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b0);
        add_row("s1_p7_c", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b1);
        add_row("s2_p3_a", 1'b1, 3'd2, 3'd3, 8'($random(seed)), 1'b0);
        add_row("s2_p3_b", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b0);
        add_row("s2_p3_c", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b1);
        add_row("s3_p5_a", 1'b1, 3'd3, 3'd5, 8'($random(seed)), 1'b0);
        add_row("s3_p5_b", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b0);
        add_row("s3_p5_c", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b0);
        add_row("s3_p5_d", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b1);
        add_row("s4_p7_a", 1'b1, 3'd4, 3'd7, 8'($random(seed)), 1'b0);
        add_row("s4_p7_b", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b0);
        add_row("s4_p7_c", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b1);
        add_row("s5_p3_a", 1'b1, 3'd5, 3'd3, 8'($random(seed)), 1'b0);
        add_row("s5_p3_b", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b0);
        add_row("s5_p3_c", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b0);
        add_row("s6_p5_a", 1'b1, 3'd6, 3'd5, 8'($random(seed)), 1'b0);
        add_row("s6_p5_b", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b1);
        add_row("s6_p5_c", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b0);
        add_row("s7_p7_a", 1'b1, 3'd7, 3'd7, 8'($random(seed)), 1'b0);
        add_row("s7_p7_b", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b0);
        add_row("s7_p7_c", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b0);
        add_row("s7_p7_d", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b1);
        // Reload of an earlier stride restarts phase and residues
        add_row("reload_a", 1'b1, 3'd3, 3'd5, 8'hF0, 1'b0);
        add_row("reload_b", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b0);
        add_row("bad_patch_a", 1'b1, 3'd3, 3'd4, 8'($random(seed)), 1'b0);
        add_row("bad_patch_b", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b0);
        add_row("zero_stride_a", 1'b1, 3'd0, 3'd5, 8'hFF, 1'b0);
        add_row("zero_stride_b", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b1);
        add_row("recover_a", 1'b1, 3'd2, 3'd7, 8'($random(seed)), 1'b0);
        add_row("recover_b", 1'b0, 3'd0, 3'd0, 8'($random(seed)), 1'b0);
    endtask

    // Walk the table with the model's own phase and residues
    task automatic fill_expected();
        int          phase;
        logic [5:0]  residue;
        logic [2:0]  cur_stride;
        logic [2:0]  cur_patch;
        logic [13:0] ctx;

        phase      = 0;
        residue    = 6'd0;
        cur_stride = 3'd0;
        cur_patch  = 3'd3;
        for (int r = 0; r < row_count; r++)
        begin
            if (row_cfg[r])
            begin
                cur_stride = row_stride[r];
                cur_patch  = row_patch[r];
                phase      = 0;
                residue    = 6'd0;
            end
            ctx = {row_word[r], residue};
            exp_mask[r] = model_mask(cur_patch, cur_stride, phase);
            for (int j = 0; j < WORD_W; j++)
                exp_win[r][j] = model_window(cur_patch, cur_stride, phase, j, ctx);
            phase   = model_phase(cur_patch, cur_stride, phase);
            residue = row_word[r][7:2];
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_valid(string name, logic expected, logic actual);
        if (actual !== expected)
            abort_run($sformatf("Fail %s out_valid: expected %0b, actual %0b",
                                name, expected, actual));
    endtask

    task automatic check_mask(string name, logic [WORD_W-1:0] expected,
                              logic [WORD_W-1:0] actual);
        if (actual !== expected)
            abort_run($sformatf("Fail %s lane_mask: expected %b, actual %b",
                                name, expected, actual));
    endtask

    task automatic check_window(string name, window_t expected, window_t actual);
        if (actual !== expected)
            abort_run($sformatf("Fail %s: expected %b, actual %b", name, expected, actual));
    endtask

    // Each word's result is due two falling edges after its strobe
    initial
    begin
        bit                pv_pipe [2];
        int                idx_pipe [2];
        logic [WORD_W-1:0] last_mask;
        window_t           last_win [WORD_W];
        string             name;

        for (int k = 0; k < 2; k++)
        begin
            pv_pipe[k]  = 1'b0;
            idx_pipe[k] = 0;
        end
        last_mask = '0;
        for (int j = 0; j < WORD_W; j++)
            last_win[j] = '0;
        wait (rst === 1'b0);
        forever
        begin
            @(negedge clk);
            name = "idle";
            if (pv_pipe[1])
            begin
                name      = row_name[idx_pipe[1]];
                last_mask = exp_mask[idx_pipe[1]];
                for (int j = 0; j < WORD_W; j++)
                    last_win[j] = exp_win[idx_pipe[1]][j];
            end
            check_valid(name, pv_pipe[1], out_valid);
            check_mask(name, last_mask, lane_mask);
            for (int j = 0; j < WORD_W; j++)
                check_window($sformatf("%s lane %0d", name, j), last_win[j], lane_windows[j]);
            pv_pipe[1]  = pv_pipe[0];
            idx_pipe[1] = idx_pipe[0];
            pv_pipe[0]  = pixel_valid;
            idx_pipe[0] = cur_row;
        end
    end

    // Watchdog
    initial
    begin
        wait (table_ready);
        #(row_count * 4 * CLK_PERIOD + 200);
        abort_run("The run timed out before every row was applied and checked");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        rst         = 1'b1;
        cfg_load    = 1'b0;
        stride      = '0;
        patch_size  = PATCH_3;
        pixel_valid = 1'b0;
        pixel_in    = '0;
        cur_row     = 0;
        row_count   = 0;
        table_ready = 1'b0;
        seed        = 32'h5614_5122;
        build_table();
        fill_expected();
        table_ready = 1'b1;

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int r = 0; r < row_count; r++)
        begin
            if (row_cfg[r])
            begin
                @(posedge clk);
                cfg_load    <= 1'b1;
                stride      <= row_stride[r];
                patch_size  <= patch_size_e'(row_patch[r]);
                pixel_valid <= 1'b0;
            end
            if (row_gap[r])
            begin
                @(posedge clk);
                cfg_load    <= 1'b0;
                pixel_valid <= 1'b0;
            end
            @(posedge clk);
            cfg_load    <= 1'b0;
            pixel_valid <= 1'b1;
            pixel_in    <= row_word[r];
            cur_row     <= r;
        end

        @(posedge clk);
        pixel_valid <= 1'b0;
        cfg_load    <= 1'b0;
        // Let the last two words drain through the pipeline
        repeat (4) @(posedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: src.f
+incdir+bench
design/remap_pkg.sv
design/stride_phase.sv
design/residue_buffer.sv
design/window_extract.sv
design/remap_top.sv
bench/remap_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the remap testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -f src.f --top-module remap_tb -o remap_sim > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/remap_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" "$SIM_LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
